//--- hw/dsp_pkg.sv
package dsp_pkg;

    localparam int DSP_WIDTH = 4;              // Slots per bundle

    localparam int ROB_DEPTH   = 16;
    localparam int ROB_ID_W    = 4;
    localparam int LBUFF_DEPTH = 8;
    localparam int LBUFF_ID_W  = 3;
    localparam int SBUFF_DEPTH = 8;
    localparam int SBUFF_ID_W  = 3;
    localparam int RSV_DEPTH   = 16;
    localparam int RSV_IDX_W   = 4;

    localparam int DECINFO_W = 29;
    localparam int SPARE_W   = 8;

    // Reserved field widths left over in each view
    localparam int AGU_RSVD_W = DECINFO_W - SPARE_W - 6;
    localparam int ALU_RSVD_W = DECINFO_W - SPARE_W - 7;

    // Execution unit codes
    localparam logic [2:0] EXEC_ALU = 3'd1;
    localparam logic [2:0] EXEC_AGU = 3'd2;
    localparam logic [2:0] EXEC_CSR = 3'd3;

    typedef struct packed {
        logic [SPARE_W-1:0]    spare;
        logic                  sync;
        logic [AGU_RSVD_W-1:0] rsvd;
        logic                  store;
        logic                  load;
        logic [2:0]            unit;
    } decinfo_agu_t;

    typedef struct packed {
        logic [SPARE_W-1:0]    spare;
        logic                  sync;
        logic [ALU_RSVD_W-1:0] rsvd;
        logic                  sfence_vma;
        logic                  fence_i;
        logic                  fence;
        logic [2:0]            unit;
    } decinfo_alu_t;

    // Same decode word, read per unit
    typedef union packed {
        decinfo_agu_t agu;
        decinfo_alu_t alu;
    } decinfo_t;

endpackage

//--- hw/dsp_id_ring.sv
module dsp_id_ring
    import dsp_pkg::*;
#(
    parameter int DEPTH = 16,
    parameter int ID_W  = 4
) (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  logic [DSP_WIDTH-1:0]           i_alloc,
    input  logic [DSP_WIDTH-1:0]           i_ret,
    output logic [DSP_WIDTH-1:0][ID_W-1:0] o_id,
    output logic [ID_W-1:0]                o_dsp_id,
    output logic [ID_W-1:0]                o_ret_id,
    output logic                           o_short
);

    localparam int CW    = $clog2(DSP_WIDTH + 1);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [ID_W-1:0]  head;
    logic [ID_W-1:0]  tail;
    logic [CNT_W-1:0] cnt;                     // IDs in flight
    logic [CW-1:0]    alloc_n;
    logic [CW-1:0]    ret_n;

    function automatic logic [ID_W-1:0] wrap_add(
        input logic [ID_W-1:0] base,
        input logic [CW-1:0]   n
    );
        logic [ID_W:0] sum;
        sum = {1'b0, base} + (ID_W + 1)'(n);
        if (sum >= (ID_W + 1)'(DEPTH)) begin
            sum = sum - (ID_W + 1)'(DEPTH);
        end
        return sum[ID_W-1:0];
    endfunction

    // Slot k gets head plus allocating slots below it
    always_comb begin
        alloc_n = '0;
        for (int k = 0; k < DSP_WIDTH; k++) begin
            o_id[k] = wrap_add(head, alloc_n);
            alloc_n = alloc_n + CW'(i_alloc[k]);
        end
    end

    assign ret_n = CW'($countones(i_ret));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            head <= '0;
            tail <= '0;
            cnt  <= '0;
        end else begin
            head <= wrap_add(head, alloc_n);
            tail <= wrap_add(tail, ret_n);
            cnt  <= cnt + CNT_W'(alloc_n) - CNT_W'(ret_n);
        end
    end

    assign o_dsp_id = head;
    assign o_ret_id = tail;
    assign o_short  = (CNT_W'(DEPTH) - cnt) < CNT_W'(DSP_WIDTH);   // Not enough for a full bundle

    // ROB can only retire what was dispatched
    a_ret_le_occ: assert property (@(posedge clk) disable iff (!i_rst_n)
        CNT_W'(ret_n) <= cnt);

endmodule

//--- hw/dsp_fmgr.sv
module dsp_fmgr
    import dsp_pkg::*;
(
    input  logic                                clk,
    input  logic                                i_rst_n,
    input  logic [DSP_WIDTH-1:0]                i_pop,
    input  logic [DSP_WIDTH-1:0]                i_ret_vld,
    input  logic [DSP_WIDTH-1:0][RSV_IDX_W-1:0] i_ret_entry,
    output logic [DSP_WIDTH-1:0][RSV_IDX_W-1:0] o_free_entry,
    output logic                                o_short
);

    localparam int CW    = $clog2(DSP_WIDTH + 1);
    localparam int CNT_W = $clog2(RSV_DEPTH + 1);

    // Free indices, circular. Pointers wrap at RSV_DEPTH = 2**RSV_IDX_W
    logic [RSV_IDX_W-1:0] list_q [RSV_DEPTH];
    logic [RSV_IDX_W-1:0] rd_ptr;
    logic [RSV_IDX_W-1:0] wr_ptr;
    logic [CNT_W-1:0]     cnt;                 // Free entries held
    logic [CW-1:0]        pop_n;
    logic [CW-1:0]        ret_n;

    logic [DSP_WIDTH-1:0][RSV_IDX_W-1:0] wr_addr;

    // Popping slots read consecutive positions in slot order
    always_comb begin
        pop_n = '0;
        for (int k = 0; k < DSP_WIDTH; k++) begin
            if (i_pop[k]) begin
                o_free_entry[k] = list_q[rd_ptr + RSV_IDX_W'(pop_n)];
            end else begin
                o_free_entry[k] = list_q[rd_ptr + RSV_IDX_W'(k)];   // Idle slot sees plain window
            end
            pop_n = pop_n + CW'(i_pop[k]);
        end
    end

    always_comb begin
        ret_n = '0;
        for (int k = 0; k < DSP_WIDTH; k++) begin
            wr_addr[k] = wr_ptr + RSV_IDX_W'(ret_n);
            ret_n      = ret_n + CW'(i_ret_vld[k]);
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            cnt    <= CNT_W'(RSV_DEPTH);
            for (int i = 0; i < RSV_DEPTH; i++) begin
                list_q[i] <= RSV_IDX_W'(i);     // Every entry free, in order
            end
        end else begin
            rd_ptr <= rd_ptr + RSV_IDX_W'(pop_n);
            wr_ptr <= wr_ptr + RSV_IDX_W'(ret_n);
            cnt    <= cnt - CNT_W'(pop_n) + CNT_W'(ret_n);
            for (int k = 0; k < DSP_WIDTH; k++) begin
                if (i_ret_vld[k]) begin
                    list_q[wr_addr[k]] <= i_ret_entry[k];
                end
            end
        end
    end

    assign o_short = cnt < CNT_W'(DSP_WIDTH);

    // More returns than were handed out
    a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
        int'(cnt) + int'(ret_n) - int'(pop_n) <= RSV_DEPTH);

    // Dispatch has to hold while the list is short
    a_no_pop_short: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_short |-> (i_pop == '0));

endmodule

//--- hw/dsp_issue_gate.sv
module dsp_issue_gate
    import dsp_pkg::*;
(
    input  logic                          clk,
    input  logic                          i_rst_n,
    input  logic [DSP_WIDTH-1:0]          i_dec_vld,
    input  decinfo_t [DSP_WIDTH-1:0]      i_dec_decinfo,
    input  logic                          i_res_stall,
    input  logic                          i_sync_csr_ret,
    input  logic                          i_sync_fence_ret,
    output logic [DSP_WIDTH-1:0]          o_fire,
    output decinfo_t [DSP_WIDTH-1:0]      o_decinfo,
    output logic                          o_ren_stall
);

    logic     csr_sync;
    logic     fence_sync;
    logic     sync_det;
    logic     marker_fire;
    logic     sync_flag_r;
    decinfo_t marker;

    // Only slot 0 is checked since the decoder puts these first
    assign csr_sync = i_dec_vld[0] && (i_dec_decinfo[0].alu.unit == EXEC_CSR)
                   && !i_sync_csr_ret;
    assign fence_sync = i_dec_vld[0] && (i_dec_decinfo[0].alu.unit == EXEC_ALU)
                     && (i_dec_decinfo[0].alu.fence || i_dec_decinfo[0].alu.fence_i
                         || i_dec_decinfo[0].alu.sfence_vma)
                     && !i_sync_fence_ret;

    assign sync_det    = csr_sync || fence_sync;
    assign marker_fire = sync_det && !sync_flag_r && !i_res_stall;
    assign o_ren_stall = i_res_stall || sync_det;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            sync_flag_r <= 1'b0;
        end else if (marker_fire) begin
            sync_flag_r <= 1'b1;                // Waiting for the marker to retire
        end else if (i_sync_csr_ret || i_sync_fence_ret) begin
            sync_flag_r <= 1'b0;
        end
    end

    always_comb begin
        marker          = '0;
        marker.alu.sync = 1'b1;
        marker.alu.unit = csr_sync ? EXEC_CSR : EXEC_ALU;
    end

    always_comb begin
        o_decinfo = i_dec_decinfo;
        if (sync_det) begin
            o_decinfo[0] = marker;
        end
    end

    always_comb begin
        if (!o_ren_stall) begin
            o_fire = i_dec_vld;
        end else if (marker_fire) begin
            o_fire = DSP_WIDTH'(1);             // Marker goes alone
        end else begin
            o_fire = '0;
        end
    end

    // A decoded word never carries the sync bit while a marker is outstanding
    a_no_marker_in_sync: assert property (@(posedge clk) disable iff (!i_rst_n)
        sync_flag_r |-> !(o_fire[0] && o_decinfo[0].alu.sync));

endmodule

//--- hw/dsp_top.sv
module dsp_top
    import dsp_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 i_rst_n,

    input  logic [DSP_WIDTH-1:0]                 i_dec_vld,
    input  decinfo_t [DSP_WIDTH-1:0]             i_dec_decinfo,

    input  logic [DSP_WIDTH-1:0]                 i_rob_ret_vld,
    input  logic [DSP_WIDTH-1:0]                 i_rob_ret_ld,
    input  logic [DSP_WIDTH-1:0]                 i_rob_ret_st,
    input  logic                                 i_rob_sync_csr_ret,
    input  logic                                 i_rob_sync_fence_ret,

    input  logic [DSP_WIDTH-1:0]                 i_rsv_free_vld,
    input  logic [DSP_WIDTH-1:0][RSV_IDX_W-1:0]  i_rsv_free_entry,

    output logic [DSP_WIDTH-1:0]                 o_dsp_rsv_vld,
    output decinfo_t [DSP_WIDTH-1:0]             o_dsp_rsv_decinfo,
    output logic [DSP_WIDTH-1:0][ROB_ID_W-1:0]   o_dsp_rsv_rob_id,
    output logic [DSP_WIDTH-1:0]                 o_dsp_rsv_ld_vld,
    output logic [DSP_WIDTH-1:0][LBUFF_ID_W-1:0] o_dsp_rsv_ld_id,
    output logic [DSP_WIDTH-1:0]                 o_dsp_rsv_st_vld,
    output logic [DSP_WIDTH-1:0][SBUFF_ID_W-1:0] o_dsp_rsv_st_id,
    output logic [DSP_WIDTH-1:0][RSV_IDX_W-1:0]  o_dsp_rsv_free_entry,

    output logic [ROB_ID_W-1:0]                  o_dsp_rob_dsp_id,
    output logic [ROB_ID_W-1:0]                  o_dsp_rob_ret_id,
    output logic [LBUFF_ID_W-1:0]                o_dsp_ld_dsp_id,
    output logic [LBUFF_ID_W-1:0]                o_dsp_ld_ret_id,
    output logic [SBUFF_ID_W-1:0]                o_dsp_st_dsp_id,
    output logic [SBUFF_ID_W-1:0]                o_dsp_st_ret_id,

    output logic                                 o_dsp_ren_stall
);

    logic [DSP_WIDTH-1:0] fire;
    logic [DSP_WIDTH-1:0] is_ld;
    logic [DSP_WIDTH-1:0] is_st;
    logic [DSP_WIDTH-1:0] ld_alloc;
    logic [DSP_WIDTH-1:0] st_alloc;
    logic [DSP_WIDTH-1:0] ld_ret;
    logic [DSP_WIDTH-1:0] st_ret;
    logic                 rob_short;
    logic                 ld_short;
    logic                 st_short;
    logic                 fmgr_short;
    logic                 res_stall;

    // Load/store class comes from the AGU view
    always_comb begin
        for (int k = 0; k < DSP_WIDTH; k++) begin
            is_ld[k] = (i_dec_decinfo[k].agu.unit == EXEC_AGU) && i_dec_decinfo[k].agu.load;
            is_st[k] = (i_dec_decinfo[k].agu.unit == EXEC_AGU) && i_dec_decinfo[k].agu.store;
        end
    end

    assign ld_alloc = fire & is_ld;
    assign st_alloc = fire & is_st;
    assign ld_ret   = i_rob_ret_vld & i_rob_ret_ld;
    assign st_ret   = i_rob_ret_vld & i_rob_ret_st;

    assign res_stall = rob_short || ld_short || st_short || fmgr_short;

    dsp_issue_gate dsp_issue_gate_i (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_dec_vld        (i_dec_vld),
        .i_dec_decinfo    (i_dec_decinfo),
        .i_res_stall      (res_stall),
        .i_sync_csr_ret   (i_rob_sync_csr_ret),
        .i_sync_fence_ret (i_rob_sync_fence_ret),
        .o_fire           (fire),
        .o_decinfo        (o_dsp_rsv_decinfo),
        .o_ren_stall      (o_dsp_ren_stall)
    );

    dsp_id_ring #(
        .DEPTH (ROB_DEPTH),
        .ID_W  (ROB_ID_W)
    ) rob_ring_i (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_alloc  (fire),
        .i_ret    (i_rob_ret_vld),
        .o_id     (o_dsp_rsv_rob_id),
        .o_dsp_id (o_dsp_rob_dsp_id),
        .o_ret_id (o_dsp_rob_ret_id),
        .o_short  (rob_short)
    );

    dsp_id_ring #(
        .DEPTH (LBUFF_DEPTH),
        .ID_W  (LBUFF_ID_W)
    ) ld_ring_i (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_alloc  (ld_alloc),
        .i_ret    (ld_ret),
        .o_id     (o_dsp_rsv_ld_id),
        .o_dsp_id (o_dsp_ld_dsp_id),
        .o_ret_id (o_dsp_ld_ret_id),
        .o_short  (ld_short)
    );

    dsp_id_ring #(
        .DEPTH (SBUFF_DEPTH),
        .ID_W  (SBUFF_ID_W)
    ) st_ring_i (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_alloc  (st_alloc),
        .i_ret    (st_ret),
        .o_id     (o_dsp_rsv_st_id),
        .o_dsp_id (o_dsp_st_dsp_id),
        .o_ret_id (o_dsp_st_ret_id),
        .o_short  (st_short)
    );

    dsp_fmgr dsp_fmgr_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_pop        (fire),
        .i_ret_vld    (i_rsv_free_vld),
        .i_ret_entry  (i_rsv_free_entry),
        .o_free_entry (o_dsp_rsv_free_entry),
        .o_short      (fmgr_short)
    );

    assign o_dsp_rsv_vld    = fire;
    assign o_dsp_rsv_ld_vld = ld_alloc;     // Only slots that really took a load ID
    assign o_dsp_rsv_st_vld = st_alloc;

endmodule

//--- test/tb_dsp_tests.svh
function automatic decinfo_t make_word(input logic [2:0] unit, input logic ld,
                                       input logic st, input logic fence);
    decinfo_t w;
    logic [31:0] r;
    r = next_rand();
    w = '0;
    w.agu.spare = r[7:0];
    w.agu.unit  = unit;
    if (ld) w.agu.load = 1'b1;
    if (st) w.agu.store = 1'b1;
    if (fence) w.alu.fence = 1'b1;
    return w;
endfunction

task automatic drive_alu_bundle();
    for (int k = 0; k < DSP_WIDTH; k++) begin
        i_dec_decinfo[k] = make_word(EXEC_ALU, 1'b0, 1'b0, 1'b0);
    end
    i_dec_vld = '1;
endtask

task automatic wait_stall(input logic level, input int max_cycles);
    int n;
    n = 0;
    while (o_dsp_ren_stall !== level && n < max_cycles) begin
        @(negedge clk);
        #1;
        n++;
    end
    if (o_dsp_ren_stall !== level) begin
        $display("Timed out after %0d cycles waiting for stall to become %0b", n, level);
        fail_stop();
    end
endtask

task automatic test_reset_state();
    apply_reset();
    #1;
    check_eq(64'(o_dsp_ren_stall), 64'(0), "stall after reset");
    check_eq(64'(o_dsp_rsv_vld), 64'(0), "vld with no input");
    check_eq(64'(o_dsp_rob_dsp_id), 64'(0), "rob dsp id");
    check_eq(64'(o_dsp_rob_ret_id), 64'(0), "rob ret id");
    check_eq(64'(o_dsp_ld_dsp_id), 64'(0), "ld dsp id");
    check_eq(64'(o_dsp_ld_ret_id), 64'(0), "ld ret id");
    check_eq(64'(o_dsp_st_dsp_id), 64'(0), "st dsp id");
    check_eq(64'(o_dsp_st_ret_id), 64'(0), "st ret id");
    for (int k = 0; k < DSP_WIDTH; k++) begin
        check_eq(64'(o_dsp_rsv_free_entry[k]), 64'(k), $sformatf("free entry slot %0d", k));
    end
endtask

task automatic test_alu_bundle();
    apply_reset();
    drive_alu_bundle();
    #1;
    check_eq(64'(o_dsp_rsv_vld), 64'hf, "full bundle fires");
    for (int k = 0; k < DSP_WIDTH; k++) begin
        check_eq(64'(o_dsp_rsv_decinfo[k]), 64'(i_dec_decinfo[k]), $sformatf("decinfo %0d", k));
        check_eq(64'(o_dsp_rsv_rob_id[k]), 64'(k), $sformatf("rob id slot %0d", k));
        check_eq(64'(o_dsp_rsv_free_entry[k]), 64'(k), $sformatf("entry slot %0d", k));
    end
    @(posedge clk);
    @(negedge clk);
    i_dec_vld = '0;
    #1;
    check_eq(64'(o_dsp_rob_dsp_id), 64'(4), "rob head after bundle");
    for (int k = 0; k < DSP_WIDTH; k++) begin
        check_eq(64'(o_dsp_rsv_free_entry[k]), 64'(k + 4), $sformatf("next entry %0d", k));
    end
endtask

task automatic test_mixed_ldst();
    apply_reset();
    // One load first so the load head is not zero
    i_dec_decinfo[0] = make_word(EXEC_AGU, 1'b1, 1'b0, 1'b0);
    i_dec_decinfo[1] = make_word(EXEC_ALU, 1'b0, 1'b0, 1'b0);
    i_dec_decinfo[2] = make_word(EXEC_ALU, 1'b0, 1'b0, 1'b0);
    i_dec_decinfo[3] = make_word(EXEC_ALU, 1'b0, 1'b0, 1'b0);
    i_dec_vld = '1;
    @(posedge clk);
    @(negedge clk);
    i_dec_decinfo[0] = make_word(EXEC_AGU, 1'b1, 1'b0, 1'b0);
    i_dec_decinfo[1] = make_word(EXEC_ALU, 1'b0, 1'b0, 1'b0);
    i_dec_decinfo[2] = make_word(EXEC_AGU, 1'b0, 1'b1, 1'b0);
    i_dec_decinfo[3] = make_word(EXEC_AGU, 1'b1, 1'b0, 1'b0);
    #1;
    check_eq(64'(o_dsp_ld_dsp_id), 64'(1), "ld head");
    check_eq(64'(o_dsp_rsv_ld_vld), 64'b1001, "ld vld");
    check_eq(64'(o_dsp_rsv_st_vld), 64'b0100, "st vld");
    check_eq(64'(o_dsp_rsv_ld_id[0]), 64'(1), "ld id slot 0");
    check_eq(64'(o_dsp_rsv_ld_id[3]), 64'(2), "ld id slot 3");
    check_eq(64'(o_dsp_rsv_st_id[2]), 64'(0), "st id slot 2");
    @(posedge clk);
    @(negedge clk);
    i_dec_vld = '0;
    #1;
    check_eq(64'(o_dsp_ld_dsp_id), 64'(3), "ld head after mix");
    check_eq(64'(o_dsp_st_dsp_id), 64'(1), "st head after mix");
    // Slot 3 flags a load but is not retiring
    @(negedge clk);
    i_rob_ret_vld = 4'b0111;
    i_rob_ret_ld  = 4'b1011;
    i_rob_ret_st  = 4'b0100;
    @(posedge clk);
    @(negedge clk);
    i_rob_ret_vld = '0;
    i_rob_ret_ld  = '0;
    i_rob_ret_st  = '0;
    #1;
    check_eq(64'(o_dsp_rob_ret_id), 64'(3), "rob tail after retire");
    check_eq(64'(o_dsp_ld_ret_id), 64'(2), "ld tail after retire");
    check_eq(64'(o_dsp_st_ret_id), 64'(1), "st tail after retire");
endtask

task automatic test_fill_and_drain();
    apply_reset();
    for (int b = 0; b < 4; b++) begin
        @(negedge clk);
        drive_alu_bundle();
        #1;
        check_eq(64'(o_dsp_ren_stall), 64'(0), $sformatf("no stall bundle %0d", b));
        check_eq(64'(o_dsp_rsv_rob_id[0]), 64'(4 * b), $sformatf("rob id bundle %0d", b));
        @(posedge clk);
    end
    @(negedge clk);
    #1;
    wait_stall(1'b1, 2);
    check_eq(64'(o_dsp_rsv_vld), 64'(0), "no fire when full");
    // Retire the oldest four and return entries 3,2,1,0
    @(negedge clk);
    i_rob_ret_vld  = '1;
    i_rsv_free_vld = '1;
    for (int k = 0; k < DSP_WIDTH; k++) begin
        i_rsv_free_entry[k] = RSV_IDX_W'(3 - k);
    end
    @(posedge clk);
    @(negedge clk);
    i_rob_ret_vld  = '0;
    i_rsv_free_vld = '0;
    #1;
    wait_stall(1'b0, 4);
    check_eq(64'(o_dsp_rsv_vld), 64'hf, "fires after drain");
    check_eq(64'(o_dsp_rob_ret_id), 64'(4), "rob ret id");
    for (int k = 0; k < DSP_WIDTH; k++) begin
        check_eq(64'(o_dsp_rsv_rob_id[k]), 64'(k), $sformatf("wrapped rob id %0d", k));
        check_eq(64'(o_dsp_rsv_free_entry[k]), 64'(3 - k), $sformatf("returned entry %0d", k));
    end
    @(negedge clk);
    i_dec_vld = '0;
endtask

task automatic test_sync_serial(input logic is_csr);
    decinfo_t marker;
    decinfo_t orig;
    apply_reset();
    drive_alu_bundle();
    if (is_csr) orig = make_word(EXEC_CSR, 1'b0, 1'b0, 1'b0);
    else orig = make_word(EXEC_ALU, 1'b0, 1'b0, 1'b1);
    i_dec_decinfo[0] = orig;
    marker          = '0;
    marker.alu.sync = 1'b1;
    marker.alu.unit = is_csr ? EXEC_CSR : EXEC_ALU;
    #1;
    check_eq(64'(o_dsp_rsv_vld), 64'b0001, "marker alone");
    check_eq(64'(o_dsp_rsv_decinfo[0]), 64'(marker), "marker word");
    check_eq(64'(o_dsp_ren_stall), 64'(1), "stall with marker");
    @(posedge clk);
    @(negedge clk);
    #1;
    check_eq(64'(o_dsp_rsv_vld), 64'(0), "hold while sync pending");
    check_eq(64'(o_dsp_ren_stall), 64'(1), "stall while sync pending");
    @(negedge clk);
    if (is_csr) i_rob_sync_csr_ret = 1'b1;
    else i_rob_sync_fence_ret = 1'b1;
    #1;
    check_eq(64'(o_dsp_ren_stall), 64'(0), "stall drops on sync retire");
    check_eq(64'(o_dsp_rsv_vld), 64'hf, "full bundle after sync");
    check_eq(64'(o_dsp_rsv_decinfo[0]), 64'(orig), "original word");
    check_eq(64'(o_dsp_rsv_rob_id[0]), 64'(1), "rob id after marker");
    @(posedge clk);
    @(negedge clk);
    i_rob_sync_csr_ret   = 1'b0;
    i_rob_sync_fence_ret = 1'b0;
    i_dec_vld            = '0;
    #1;
    check_eq(64'(o_dsp_rob_dsp_id), 64'(5), "rob head after sync");
endtask

//--- test/tb_dsp_top.sv
module tb_dsp_top
    import dsp_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic                                 clk;
    logic                                 i_rst_n;
    logic [DSP_WIDTH-1:0]                 i_dec_vld;
    decinfo_t [DSP_WIDTH-1:0]             i_dec_decinfo;
    logic [DSP_WIDTH-1:0]                 i_rob_ret_vld;
    logic [DSP_WIDTH-1:0]                 i_rob_ret_ld;
    logic [DSP_WIDTH-1:0]                 i_rob_ret_st;
    logic                                 i_rob_sync_csr_ret;
    logic                                 i_rob_sync_fence_ret;
    logic [DSP_WIDTH-1:0]                 i_rsv_free_vld;
    logic [DSP_WIDTH-1:0][RSV_IDX_W-1:0]  i_rsv_free_entry;

    logic [DSP_WIDTH-1:0]                 o_dsp_rsv_vld;
    decinfo_t [DSP_WIDTH-1:0]             o_dsp_rsv_decinfo;
    logic [DSP_WIDTH-1:0][ROB_ID_W-1:0]   o_dsp_rsv_rob_id;
    logic [DSP_WIDTH-1:0]                 o_dsp_rsv_ld_vld;
    logic [DSP_WIDTH-1:0][LBUFF_ID_W-1:0] o_dsp_rsv_ld_id;
    logic [DSP_WIDTH-1:0]                 o_dsp_rsv_st_vld;
    logic [DSP_WIDTH-1:0][SBUFF_ID_W-1:0] o_dsp_rsv_st_id;
    logic [DSP_WIDTH-1:0][RSV_IDX_W-1:0]  o_dsp_rsv_free_entry;
    logic [ROB_ID_W-1:0]                  o_dsp_rob_dsp_id;
    logic [ROB_ID_W-1:0]                  o_dsp_rob_ret_id;
    logic [LBUFF_ID_W-1:0]                o_dsp_ld_dsp_id;
    logic [LBUFF_ID_W-1:0]                o_dsp_ld_ret_id;
    logic [SBUFF_ID_W-1:0]                o_dsp_st_dsp_id;
    logic [SBUFF_ID_W-1:0]                o_dsp_st_ret_id;
    logic                                 o_dsp_ren_stall;

    logic [31:0] rng_state;

    dsp_top dsp_top_i (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;                       // 8 ns period

    task automatic fail_stop();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
            fail_stop();
        end
    endtask

    // Xorshift32 for the spare decode bits
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic clear_inputs();
        i_dec_vld            = '0;
        i_dec_decinfo        = '0;
        i_rob_ret_vld        = '0;
        i_rob_ret_ld         = '0;
        i_rob_ret_st         = '0;
        i_rob_sync_csr_ret   = 1'b0;
        i_rob_sync_fence_ret = 1'b0;
        i_rsv_free_vld       = '0;
        i_rsv_free_entry     = '0;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        i_rst_n = 1'b0;
        clear_inputs();
        repeat (4) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;
    endtask

    `include "tb_dsp_tests.svh"

    initial begin
        rng_state = 32'd89978;
        i_rst_n   = 1'b0;
        clear_inputs();
        test_reset_state();
        test_alu_bundle();
        test_mixed_ldst();
        test_fill_and_drain();
        test_sync_serial(1'b1);
        test_sync_serial(1'b0);
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+test
hw/dsp_pkg.sv
hw/dsp_id_ring.sv
hw/dsp_fmgr.sv
hw/dsp_issue_gate.sv
hw/dsp_top.sv
test/tb_dsp_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the dispatch-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f vlog.f --top-module tb_dsp_top -o tb_sim \
    && ./obj_dir/tb_sim > "$LOG" 2>&1 \
    || echo "build or simulation returned an error" >> "$LOG"

cat "$LOG"

grep -q "PASS: all tests" "$LOG" && echo "run.sh: simulation passed" && exit 0 \
    || { echo "run.sh: simulation failed"; exit 1; }
